/* src/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [15:0] imm16_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam int        NUM_GPR  = 32;
    localparam reg_addr_t LINK_REG = 5'd31; // jal return address

    // op field
    localparam opcode_t OP_SPECIAL = 6'h00;
    localparam opcode_t OP_REGIMM  = 6'h01;
    localparam opcode_t OP_J       = 6'h02;
    localparam opcode_t OP_JAL     = 6'h03;
    localparam opcode_t OP_BEQ     = 6'h04;
    localparam opcode_t OP_BNE     = 6'h05;
    localparam opcode_t OP_BLEZ    = 6'h06;
    localparam opcode_t OP_BGTZ    = 6'h07;
    localparam opcode_t OP_ADDI    = 6'h08;
    localparam opcode_t OP_ADDIU   = 6'h09;
    localparam opcode_t OP_SLTI    = 6'h0a;
    localparam opcode_t OP_SLTIU   = 6'h0b;
    localparam opcode_t OP_ANDI    = 6'h0c;
    localparam opcode_t OP_ORI     = 6'h0d;
    localparam opcode_t OP_XORI    = 6'h0e;
    localparam opcode_t OP_LUI     = 6'h0f;
    localparam opcode_t OP_LB      = 6'h20;
    localparam opcode_t OP_LH      = 6'h21;
    localparam opcode_t OP_LW      = 6'h23;
    localparam opcode_t OP_LBU     = 6'h24;
    localparam opcode_t OP_LHU     = 6'h25;
    localparam opcode_t OP_SB      = 6'h28;
    localparam opcode_t OP_SH      = 6'h29;
    localparam opcode_t OP_SW      = 6'h2b;

    // funct field of SPECIAL
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // rt field of REGIMM
    localparam reg_addr_t RI_BLTZ = 5'h00;
    localparam reg_addr_t RI_BGEZ = 5'h01;

endpackage

`default_nettype wire

/* src/id_ctrl_pkg.sv */
`default_nettype none

package id_ctrl_pkg;

    // numeric codes follow the listing order, NOP is 0
    typedef enum logic [7:0] {
        ALUOP_NOP,
        ALUOP_AND,  ALUOP_OR,    ALUOP_XOR,  ALUOP_NOR,
        ALUOP_ADD,  ALUOP_ADDU,  ALUOP_SUB,  ALUOP_SUBU,
        ALUOP_SLT,  ALUOP_SLTU,
        ALUOP_SLL,  ALUOP_SRL,   ALUOP_SRA,
        ALUOP_SLLV, ALUOP_SRLV,  ALUOP_SRAV,
        ALUOP_ANDI, ALUOP_ORI,   ALUOP_XORI,
        ALUOP_ADDI, ALUOP_ADDIU, ALUOP_SLTI, ALUOP_SLTIU,
        ALUOP_LUI,
        ALUOP_LB,   ALUOP_LBU,   ALUOP_LH,   ALUOP_LHU,  ALUOP_LW,
        ALUOP_SB,   ALUOP_SH,    ALUOP_SW,
        ALUOP_BEQ,  ALUOP_BNE,   ALUOP_BGTZ, ALUOP_BLEZ,
        ALUOP_BGEZ, ALUOP_BLTZ,
        ALUOP_J,    ALUOP_JAL,   ALUOP_JR
    } aluop_t;

    // nine kinds, so four bits
    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_GTZ, BR_LEZ, BR_GEZ, BR_LTZ, BR_JUMP, BR_REG
    } br_kind_t;

endpackage

`default_nettype wire

/* src/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_file import mips_isa_pkg::*; (
    input  wire       clk_i,
    input  wire       rst_n_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o,
    input  wire       we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i
);

    word_t regs [NUM_GPR];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin // r0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // no write-through, a write shows after the edge
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

`default_nettype wire

/* src/operand_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_bypass import mips_isa_pkg::*; (
    input  reg_addr_t rs_addr_i,
    input  reg_addr_t rt_addr_i,
    input  wire       rs_re_i,
    input  wire       rt_re_i,
    input  word_t     rf_rs_i,
    input  word_t     rf_rt_i,
    input  wire       ex_we_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,
    input  wire       ex_load_i,
    input  wire       mem_we_i,
    input  reg_addr_t mem_waddr_i,
    input  word_t     mem_wdata_i,
    output word_t     rs_data_o,
    output word_t     rt_data_o,
    output logic      stall_o
);

    // youngest producer wins
    function automatic word_t pick(input reg_addr_t addr, input logic re, input word_t rf_val);
        if (!re || addr == '0) begin
            return '0;
        end else if (ex_we_i && ex_waddr_i == addr) begin
            return ex_wdata_i;
        end else if (mem_we_i && mem_waddr_i == addr) begin
            return mem_wdata_i;
        end
        return rf_val;
    endfunction

    always_comb begin
        rs_data_o = pick(rs_addr_i, rs_re_i, rf_rs_i);
        rt_data_o = pick(rt_addr_i, rt_re_i, rf_rt_i);
    end

    // load in execute has no data yet
    assign stall_o = ex_load_i && ex_waddr_i != '0
                   && ((rs_re_i && ex_waddr_i == rs_addr_i)
                    || (rt_re_i && ex_waddr_i == rt_addr_i));

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  word_t     instr_i,
    output aluop_t    aluop_o,
    output br_kind_t  br_kind_o,
    output logic      rs_re_o,
    output logic      rt_re_o,
    output logic      rf_we_o,
    output reg_addr_t rf_waddr_o,
    output logic      mem_we_o,
    output logic      mem_to_reg_o,
    output logic      link_o,
    output logic      invalid_o
);

    opcode_t   op;
    reg_addr_t rt;
    reg_addr_t rd;
    funct_t    funct;

    assign op    = instr_i[31:26];
    assign rt    = instr_i[20:16];
    assign rd    = instr_i[15:11];
    assign funct = instr_i[5:0];

    // operation select, NOP marks anything not decoded
    always_comb begin
        aluop_o = ALUOP_NOP;
        case (op)
            OP_SPECIAL: begin
                case (funct)
                    FN_AND:  aluop_o = ALUOP_AND;
                    FN_OR:   aluop_o = ALUOP_OR;
                    FN_XOR:  aluop_o = ALUOP_XOR;
                    FN_NOR:  aluop_o = ALUOP_NOR;
                    FN_ADD:  aluop_o = ALUOP_ADD;
                    FN_ADDU: aluop_o = ALUOP_ADDU;
                    FN_SUB:  aluop_o = ALUOP_SUB;
                    FN_SUBU: aluop_o = ALUOP_SUBU;
                    FN_SLT:  aluop_o = ALUOP_SLT;
                    FN_SLTU: aluop_o = ALUOP_SLTU;
                    FN_SLL:  aluop_o = ALUOP_SLL;
                    FN_SRL:  aluop_o = ALUOP_SRL;
                    FN_SRA:  aluop_o = ALUOP_SRA;
                    FN_SLLV: aluop_o = ALUOP_SLLV;
                    FN_SRLV: aluop_o = ALUOP_SRLV;
                    FN_SRAV: aluop_o = ALUOP_SRAV;
                    FN_JR:   aluop_o = ALUOP_JR;
                    default: aluop_o = ALUOP_NOP;
                endcase
            end
            OP_REGIMM: begin
                if (rt == RI_BGEZ) begin
                    aluop_o = ALUOP_BGEZ;
                end else if (rt == RI_BLTZ) begin
                    aluop_o = ALUOP_BLTZ;
                end
            end
            OP_ANDI:  aluop_o = ALUOP_ANDI;
            OP_ORI:   aluop_o = ALUOP_ORI;
            OP_XORI:  aluop_o = ALUOP_XORI;
            OP_ADDI:  aluop_o = ALUOP_ADDI;
            OP_ADDIU: aluop_o = ALUOP_ADDIU;
            OP_SLTI:  aluop_o = ALUOP_SLTI;
            OP_SLTIU: aluop_o = ALUOP_SLTIU;
            OP_LUI:   aluop_o = ALUOP_LUI;
            OP_LB:    aluop_o = ALUOP_LB;
            OP_LBU:   aluop_o = ALUOP_LBU;
            OP_LH:    aluop_o = ALUOP_LH;
            OP_LHU:   aluop_o = ALUOP_LHU;
            OP_LW:    aluop_o = ALUOP_LW;
            OP_SB:    aluop_o = ALUOP_SB;
            OP_SH:    aluop_o = ALUOP_SH;
            OP_SW:    aluop_o = ALUOP_SW;
            OP_BEQ:   aluop_o = ALUOP_BEQ;
            OP_BNE:   aluop_o = ALUOP_BNE;
            OP_BGTZ:  aluop_o = ALUOP_BGTZ;
            OP_BLEZ:  aluop_o = ALUOP_BLEZ;
            OP_J:     aluop_o = ALUOP_J;
            OP_JAL:   aluop_o = ALUOP_JAL;
            default:  aluop_o = ALUOP_NOP;
        endcase
    end

    // control set per instruction class
    always_comb begin
        br_kind_o    = BR_NONE;
        rs_re_o      = 1'b0;
        rt_re_o      = 1'b0;
        rf_we_o      = 1'b0;
        rf_waddr_o   = '0;
        mem_we_o     = 1'b0;
        mem_to_reg_o = 1'b0;
        link_o       = 1'b0;
        invalid_o    = 1'b0;
        case (aluop_o)
            ALUOP_AND, ALUOP_OR, ALUOP_XOR, ALUOP_NOR, ALUOP_ADD, ALUOP_ADDU,
            ALUOP_SUB, ALUOP_SUBU, ALUOP_SLT, ALUOP_SLTU,
            ALUOP_SLLV, ALUOP_SRLV, ALUOP_SRAV: begin
                rs_re_o    = 1'b1;
                rt_re_o    = 1'b1;
                rf_we_o    = 1'b1;
                rf_waddr_o = rd;
            end
            ALUOP_SLL, ALUOP_SRL, ALUOP_SRA: begin // shamt from the immediate
                rt_re_o    = 1'b1;
                rf_we_o    = 1'b1;
                rf_waddr_o = rd;
            end
            ALUOP_ANDI, ALUOP_ORI, ALUOP_XORI, ALUOP_ADDI, ALUOP_ADDIU,
            ALUOP_SLTI, ALUOP_SLTIU, ALUOP_LUI: begin
                rs_re_o    = (aluop_o != ALUOP_LUI); // lui has no source
                rf_we_o    = 1'b1;
                rf_waddr_o = rt;
            end
            ALUOP_LB, ALUOP_LBU, ALUOP_LH, ALUOP_LHU, ALUOP_LW: begin
                rs_re_o      = 1'b1;
                rf_we_o      = 1'b1;
                rf_waddr_o   = rt;
                mem_to_reg_o = 1'b1;
            end
            ALUOP_SB, ALUOP_SH, ALUOP_SW: begin
                rs_re_o  = 1'b1;
                rt_re_o  = 1'b1;
                mem_we_o = 1'b1;
            end
            ALUOP_BEQ, ALUOP_BNE: begin
                rs_re_o   = 1'b1;
                rt_re_o   = 1'b1;
                br_kind_o = (aluop_o == ALUOP_BEQ) ? BR_EQ : BR_NE;
            end
            ALUOP_BGTZ: begin
                rs_re_o   = 1'b1;
                br_kind_o = BR_GTZ;
            end
            ALUOP_BLEZ: begin
                rs_re_o   = 1'b1;
                br_kind_o = BR_LEZ;
            end
            ALUOP_BGEZ: begin
                rs_re_o   = 1'b1;
                br_kind_o = BR_GEZ;
            end
            ALUOP_BLTZ: begin
                rs_re_o   = 1'b1;
                br_kind_o = BR_LTZ;
            end
            ALUOP_J: br_kind_o = BR_JUMP;
            ALUOP_JAL: begin
                br_kind_o  = BR_JUMP;
                rf_we_o    = 1'b1;
                rf_waddr_o = LINK_REG;
                link_o     = 1'b1;
            end
            ALUOP_JR: begin
                rs_re_o   = 1'b1;
                br_kind_o = BR_REG;
            end
            default: invalid_o = 1'b1; // reserved instruction
        endcase
    end

endmodule

`default_nettype wire

/* src/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  br_kind_t br_kind_i,
    input  word_t    pc_i,
    input  word_t    instr_i,
    input  word_t    rs_data_i,
    input  word_t    rt_data_i,
    output logic     taken_o,
    output word_t    target_o,
    output word_t    link_addr_o
);

    word_t pc_add4;
    word_t br_target;
    word_t jmp_target;
    logic  rs_zero;
    logic  rs_neg;

    assign pc_add4     = pc_i + 32'd4;
    assign link_addr_o = pc_i + 32'd8; // past the delay slot
    assign br_target   = pc_add4 + {{14{instr_i[15]}}, instr_i[15:0], 2'b00};
    assign jmp_target  = {pc_add4[31:28], instr_i[25:0], 2'b00};
    assign rs_zero     = (rs_data_i == '0);
    assign rs_neg      = rs_data_i[31];

    always_comb begin
        case (br_kind_i)
            BR_EQ:   taken_o = (rs_data_i == rt_data_i);
            BR_NE:   taken_o = (rs_data_i != rt_data_i);
            BR_GTZ:  taken_o = !rs_neg && !rs_zero;
            BR_LEZ:  taken_o = rs_neg || rs_zero;
            BR_GEZ:  taken_o = !rs_neg;
            BR_LTZ:  taken_o = rs_neg;
            BR_JUMP: taken_o = 1'b1;
            BR_REG:  taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

    always_comb begin
        if (!taken_o) begin
            target_o = '0;
        end else if (br_kind_i == BR_JUMP) begin
            target_o = jmp_target;
        end else if (br_kind_i == BR_REG) begin
            target_o = rs_data_i;
        end else begin
            target_o = br_target;
        end
    end

endmodule

`default_nettype wire

/* src/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  wire       clk_i,
    input  wire       rst_n_i,
    input  wire       load_i,
    input  aluop_t    aluop_i,
    input  wire       rf_we_i,
    input  reg_addr_t rf_waddr_i,
    input  wire       mem_we_i,
    input  wire       mem_to_reg_i,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  imm16_t    imm_i,
    input  wire       invalid_i,
    output logic      ex_valid_o,
    output aluop_t    ex_aluop_o,
    output logic      ex_rf_we_o,
    output reg_addr_t ex_rf_waddr_o,
    output logic      ex_mem_we_o,
    output logic      ex_mem_to_reg_o,
    output word_t     ex_rs_data_o,
    output word_t     ex_rt_data_o,
    output imm16_t    ex_imm_o,
    output logic      ex_invalid_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !load_i) begin // bubble
            ex_valid_o      <= 1'b0;
            ex_aluop_o      <= ALUOP_NOP;
            ex_rf_we_o      <= 1'b0;
            ex_rf_waddr_o   <= '0;
            ex_mem_we_o     <= 1'b0;
            ex_mem_to_reg_o <= 1'b0;
            ex_rs_data_o    <= '0;
            ex_rt_data_o    <= '0;
            ex_imm_o        <= '0;
            ex_invalid_o    <= 1'b0;
        end else begin
            ex_valid_o      <= 1'b1;
            ex_aluop_o      <= aluop_i;
            ex_rf_we_o      <= rf_we_i;
            ex_rf_waddr_o   <= rf_waddr_i;
            ex_mem_we_o     <= mem_we_i;
            ex_mem_to_reg_o <= mem_to_reg_i;
            ex_rs_data_o    <= rs_data_i; // link address for jal
            ex_rt_data_o    <= rt_data_i;
            ex_imm_o        <= imm_i;
            ex_invalid_o    <= invalid_i;
        end
    end

endmodule

`default_nettype wire

/* src/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage import mips_isa_pkg::*, id_ctrl_pkg::*; (
    input  wire       clk_i,
    input  wire       rst_n_i,
    input  wire       id_valid_i,
    input  word_t     pc_i,
    input  word_t     instr_i,
    input  wire       ex_we_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,
    input  wire       ex_load_i,
    input  wire       mem_we_i,
    input  reg_addr_t mem_waddr_i,
    input  word_t     mem_wdata_i,
    input  wire       wb_we_i,
    input  reg_addr_t wb_waddr_i,
    input  word_t     wb_wdata_i,
    output logic      id_stall_o,
    output logic      branch_taken_o,
    output word_t     branch_target_o,
    output logic      ex_valid_o,
    output aluop_t    ex_aluop_o,
    output logic      ex_rf_we_o,
    output reg_addr_t ex_rf_waddr_o,
    output logic      ex_mem_we_o,
    output logic      ex_mem_to_reg_o,
    output word_t     ex_rs_data_o,
    output word_t     ex_rt_data_o,
    output imm16_t    ex_imm_o,
    output logic      ex_invalid_o
);

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    aluop_t    aluop;
    br_kind_t  br_kind;
    logic      rs_re;
    logic      rt_re;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      mem_we;
    logic      mem_to_reg;
    logic      link;
    logic      invalid;
    word_t     rf_rs;
    word_t     rf_rt;
    word_t     rs_data;
    word_t     rt_data;
    logic      hazard;
    logic      taken;
    word_t     target;
    word_t     link_addr;
    logic      go;

    assign rs_addr = instr_i[25:21];
    assign rt_addr = instr_i[20:16];

    gpr_file u_gpr_file (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rs_addr),
        .raddr_b_i (rt_addr),
        .rdata_a_o (rf_rs),
        .rdata_b_o (rf_rt),
        .we_i      (wb_we_i),
        .waddr_i   (wb_waddr_i),
        .wdata_i   (wb_wdata_i)
    );

    instr_decoder u_instr_decoder (
        .instr_i      (instr_i),
        .aluop_o      (aluop),
        .br_kind_o    (br_kind),
        .rs_re_o      (rs_re),
        .rt_re_o      (rt_re),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .mem_we_o     (mem_we),
        .mem_to_reg_o (mem_to_reg),
        .link_o       (link),
        .invalid_o    (invalid)
    );

    operand_bypass u_operand_bypass (
        .rs_addr_i   (rs_addr),
        .rt_addr_i   (rt_addr),
        .rs_re_i     (rs_re),
        .rt_re_i     (rt_re),
        .rf_rs_i     (rf_rs),
        .rf_rt_i     (rf_rt),
        .ex_we_i     (ex_we_i),
        .ex_waddr_i  (ex_waddr_i),
        .ex_wdata_i  (ex_wdata_i),
        .ex_load_i   (ex_load_i),
        .mem_we_i    (mem_we_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .rs_data_o   (rs_data),
        .rt_data_o   (rt_data),
        .stall_o     (hazard)
    );

    branch_unit u_branch_unit (
        .br_kind_i   (br_kind),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .taken_o     (taken),
        .target_o    (target),
        .link_addr_o (link_addr)
    );

    // operands are stale while stalled, so branch only on a clean strobe
    assign go              = id_valid_i && !hazard;
    assign id_stall_o      = id_valid_i && hazard;
    assign branch_taken_o  = go && taken;
    assign branch_target_o = go ? target : '0;

    id_ex_reg u_id_ex_reg (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .load_i          (go),
        .aluop_i         (aluop),
        .rf_we_i         (rf_we),
        .rf_waddr_i      (rf_waddr),
        .mem_we_i        (mem_we),
        .mem_to_reg_i    (mem_to_reg),
        .rs_data_i       (link ? link_addr : rs_data),
        .rt_data_i       (rt_data),
        .imm_i           (instr_i[15:0]),
        .invalid_i       (invalid),
        .ex_valid_o      (ex_valid_o),
        .ex_aluop_o      (ex_aluop_o),
        .ex_rf_we_o      (ex_rf_we_o),
        .ex_rf_waddr_o   (ex_rf_waddr_o),
        .ex_mem_we_o     (ex_mem_we_o),
        .ex_mem_to_reg_o (ex_mem_to_reg_o),
        .ex_rs_data_o    (ex_rs_data_o),
        .ex_rt_data_o    (ex_rt_data_o),
        .ex_imm_o        (ex_imm_o),
        .ex_invalid_o    (ex_invalid_o)
    );

endmodule

`default_nettype wire

/* tests/id_stage_props.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_props (
    input wire clk_i,
    input wire rst_n_i,
    input wire valid_i,
    input wire stall_i,
    input wire taken_i,
    input wire ex_valid_i,
    input wire ex_rf_we_i,
    input wire ex_mem_we_i
);

    no_valid_after_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_i |=> !ex_valid_i)
        else $error("ex_valid_o high in the cycle after a stalled strobe");

    bubble_has_no_writes: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !ex_valid_i |-> (!ex_rf_we_i && !ex_mem_we_i))
        else $error("bubble carries a write enable");

    taken_needs_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        taken_i |-> valid_i)
        else $error("branch_taken_o high without id_valid_i");

endmodule

bind id_stage id_stage_props u_id_stage_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (id_valid_i),
    .stall_i     (id_stall_o),
    .taken_i     (branch_taken_o),
    .ex_valid_i  (ex_valid_o),
    .ex_rf_we_i  (ex_rf_we_o),
    .ex_mem_we_i (ex_mem_we_o)
);

`default_nettype wire

/* tests/id_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb
    import mips_isa_pkg::*, id_ctrl_pkg::*;
();

    logic      clk;
    logic      rst_n;
    logic      id_valid;
    word_t     pc;
    word_t     instr;
    logic      ex_we;
    reg_addr_t ex_waddr;
    word_t     ex_wdata;
    logic      ex_load;
    logic      mem_we;
    reg_addr_t mem_waddr;
    word_t     mem_wdata;
    logic      wb_we;
    reg_addr_t wb_waddr;
    word_t     wb_wdata;
    logic      id_stall;
    logic      br_taken;
    word_t     br_target;
    logic      ex_valid;
    aluop_t    ex_aluop;
    logic      ex_rf_we;
    reg_addr_t ex_rf_waddr;
    logic      ex_mem_we;
    logic      ex_mem_to_reg;
    word_t     ex_rs_data;
    word_t     ex_rt_data;
    imm16_t    ex_imm;
    logic      ex_invalid;
    int        rec_no;

    id_stage u_id_stage (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .id_valid_i      (id_valid),
        .pc_i            (pc),
        .instr_i         (instr),
        .ex_we_i         (ex_we),
        .ex_waddr_i      (ex_waddr),
        .ex_wdata_i      (ex_wdata),
        .ex_load_i       (ex_load),
        .mem_we_i        (mem_we),
        .mem_waddr_i     (mem_waddr),
        .mem_wdata_i     (mem_wdata),
        .wb_we_i         (wb_we),
        .wb_waddr_i      (wb_waddr),
        .wb_wdata_i      (wb_wdata),
        .id_stall_o      (id_stall),
        .branch_taken_o  (br_taken),
        .branch_target_o (br_target),
        .ex_valid_o      (ex_valid),
        .ex_aluop_o      (ex_aluop),
        .ex_rf_we_o      (ex_rf_we),
        .ex_rf_waddr_o   (ex_rf_waddr),
        .ex_mem_we_o     (ex_mem_we),
        .ex_mem_to_reg_o (ex_mem_to_reg),
        .ex_rs_data_o    (ex_rs_data),
        .ex_rt_data_o    (ex_rt_data),
        .ex_imm_o        (ex_imm),
        .ex_invalid_o    (ex_invalid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk; // 4 ns period
        end
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h expected 0x%h at record %0d",
                     name, got, exp, rec_no);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic idle_inputs();
        id_valid  = 1'b0;
        pc        = '0;
        instr     = '0;
        ex_we     = 1'b0;
        ex_waddr  = '0;
        ex_wdata  = '0;
        ex_load   = 1'b0;
        mem_we    = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        wb_we     = 1'b0;
        wb_waddr  = '0;
        wb_wdata  = '0;
    endtask

    task automatic check_bubble();
        check("ex_valid_o", 32'(ex_valid), 32'h0);
        check("ex_aluop_o", 32'(ex_aluop), 32'h0);
        check("ex_rf_we_o", 32'(ex_rf_we), 32'h0);
        check("ex_rf_waddr_o", 32'(ex_rf_waddr), 32'h0);
        check("ex_mem_we_o", 32'(ex_mem_we), 32'h0);
        check("ex_mem_to_reg_o", 32'(ex_mem_to_reg), 32'h0);
        check("ex_rs_data_o", ex_rs_data, 32'h0);
        check("ex_rt_data_o", ex_rt_data, 32'h0);
        check("ex_imm_o", 32'(ex_imm), 32'h0);
        check("ex_invalid_o", 32'(ex_invalid), 32'h0);
    endtask

    // inputs of the last record stay on the bus with the strobe low
    task automatic idle_cycles(input int n);
        id_valid = 1'b0;
        repeat (n) begin
            @(negedge clk);
            check_bubble();
            check("id_stall_o", 32'(id_stall), 32'h0);
            check("branch_taken_o", 32'(br_taken), 32'h0);
            check("branch_target_o", br_target, 32'h0);
        end
    endtask

    task automatic await_result(input logic expect_valid);
        int cycles;
        @(negedge clk);
        cycles   = 1;
        id_valid = 1'b0; // strobe lasts one cycle
        while (expect_valid && !ex_valid && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        if (expect_valid && !ex_valid) begin
            stop_with_error("timeout: ex_valid_o did not rise within 4 cycles of the strobe");
        end else if (expect_valid) begin
            check("ex_valid_o latency", 32'(cycles), 32'd1);
        end
    endtask

    task automatic apply_write(input string line);
        word_t addr;
        word_t data;
        int    n;
        n = $sscanf(line, "W %h %h", addr, data);
        if (n != 2) begin
            stop_with_error({"malformed W record: ", line});
        end else begin
            wb_we    = 1'b1;
            wb_waddr = addr[4:0];
            wb_wdata = data;
            @(negedge clk);
            wb_we    = 1'b0;
        end
    endtask

    task automatic run_decode(input string line);
        word_t f [21];
        int    n;
        n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
        if (n != 21) begin
            stop_with_error({"malformed D record: ", line});
        end else begin
            pc        = f[0];
            instr     = f[1];
            ex_we     = f[2][0];
            ex_waddr  = f[3][4:0];
            ex_wdata  = f[4];
            ex_load   = f[5][0];
            mem_we    = f[6][0];
            mem_waddr = f[7][4:0];
            mem_wdata = f[8];
            id_valid  = 1'b1;
            #1; // combinational outputs settle well before the edge
            check("id_stall_o", 32'(id_stall), f[9]);
            check("branch_taken_o", 32'(br_taken), f[10]);
            check("branch_target_o", br_target, f[11]);
            await_result(!f[9][0]);
            check("ex_valid_o", 32'(ex_valid), 32'(!f[9][0]));
            check("ex_aluop_o", 32'(ex_aluop), f[12]);
            check("ex_rf_we_o", 32'(ex_rf_we), f[13]);
            check("ex_rf_waddr_o", 32'(ex_rf_waddr), f[14]);
            check("ex_mem_we_o", 32'(ex_mem_we), f[15]);
            check("ex_mem_to_reg_o", 32'(ex_mem_to_reg), f[16]);
            check("ex_rs_data_o", ex_rs_data, f[17]);
            check("ex_rt_data_o", ex_rt_data, f[18]);
            check("ex_imm_o", 32'(ex_imm), f[19]);
            check("ex_invalid_o", 32'(ex_invalid), f[20]);
        end
    endtask

    initial begin
        #20000;
        stop_with_error("watchdog expired before the run finished");
    end

    initial begin
        int    fd;
        string line;
        void'($urandom(30));
        idle_inputs();
        id_valid = 1'b1; // a strobe during reset still leaves a bubble
        instr    = 32'h00222820;
        rst_n    = 1'b0;
        rec_no   = 0;
        repeat (4) @(negedge clk);
        check_bubble(); // cleared by reset
        idle_inputs();
        rst_n = 1'b1;
        fd = $fopen("tests/id_tests.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open tests/id_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                if (line.getc(0) == "W") begin
                    apply_write(line);
                end else if (line.getc(0) == "D") begin
                    rec_no++;
                    run_decode(line);
                    idle_cycles(int'($urandom % 3));
                end else begin
                    stop_with_error({"unknown record in data file: ", line});
                end
            end
            $fclose(fd);
        end
        if (rec_no == 0) begin
            stop_with_error("no decode records were read");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/id_tests.txt */
# W wb_addr wb_data
# D pc instr ex_we ex_wa ex_wd ex_ld mem_we mem_wa mem_wd stall taken target aluop rf_we rf_wa mem_we mem_to_reg rs rt imm inv
W 01 00000011
W 02 00000022
W 03 80000000
W 04 00000022
W 08 00400000
W 00 ffffffff
# alu, shift and immediate
D 00001000 00222820 0 00 00000000 0 0 00 00000000 0 0 00000000 05 1 05 0 0 00000011 00000022 2820 0
D 00001004 00023100 0 00 00000000 0 0 00 00000000 0 0 00000000 0b 1 06 0 0 00000000 00000022 3100 0
D 00001008 342700ff 0 00 00000000 0 0 00 00000000 0 0 00000000 12 1 07 0 0 00000011 00000000 00ff 0
D 0000100c 3c091234 0 00 00000000 0 0 00 00000000 0 0 00000000 18 1 09 0 0 00000000 00000000 1234 0
D 00001010 00225027 0 00 00000000 0 0 00 00000000 0 0 00000000 04 1 0a 0 0 00000011 00000022 5027 0
# forwarding priority and r0
D 00001014 00222820 1 01 aaaa0001 0 1 01 bbbb0001 0 0 00000000 05 1 05 0 0 aaaa0001 00000022 2820 0
D 00001018 00222820 0 01 aaaa0001 0 1 01 bbbb0001 0 0 00000000 05 1 05 0 0 bbbb0001 00000022 2820 0
D 0000101c 00022820 1 00 dddd0000 0 1 00 eeee0000 0 0 00000000 05 1 05 0 0 00000000 00000022 2820 0
# load-use stall, re-strobe, load on a register that is not read
D 00001020 00222820 1 02 12345678 1 0 00 00000000 1 0 00000000 00 0 00 0 0 00000000 00000000 0000 0
D 00001020 00222820 0 00 00000000 0 0 00 00000000 0 0 00000000 05 1 05 0 0 00000011 00000022 2820 0
D 00001024 342700ff 1 07 99999999 1 0 00 00000000 0 0 00000000 12 1 07 0 0 00000011 00000000 00ff 0
# branches and jumps
D 00002000 10440004 0 00 00000000 0 0 00 00000000 0 1 00002014 21 0 00 0 0 00000022 00000022 0004 0
D 00002000 1422fffe 0 00 00000000 0 0 00 00000000 0 1 00001ffc 22 0 00 0 0 00000011 00000022 fffe 0
D 00002000 1c600008 0 00 00000000 0 0 00 00000000 0 0 00000000 23 0 00 0 0 80000000 00000000 0008 0
D 00002000 18600008 0 00 00000000 0 0 00 00000000 0 1 00002024 24 0 00 0 0 80000000 00000000 0008 0
D 00002000 04210003 0 00 00000000 0 0 00 00000000 0 1 00002010 25 0 00 0 0 00000011 00000000 0003 0
D 00002000 04200003 0 00 00000000 0 0 00 00000000 0 0 00000000 26 0 00 0 0 00000011 00000000 0003 0
D 00002000 08000100 0 00 00000000 0 0 00 00000000 0 1 00000400 27 0 00 0 0 00000000 00000000 0100 0
D 00002000 0c000100 0 00 00000000 0 0 00 00000000 0 1 00000400 28 1 1f 0 0 00002008 00000000 0100 0
D 00002000 01000008 0 00 00000000 0 0 00 00000000 0 1 00400000 29 0 00 0 0 00400000 00000000 0008 0
# loads, stores, undefined
D 00003000 8c2b0004 0 00 00000000 0 0 00 00000000 0 0 00000000 1d 1 0b 0 1 00000011 00000000 0004 0
D 00003004 ac220008 0 00 00000000 0 0 00 00000000 0 0 00000000 20 0 00 1 0 00000011 00000022 0008 0
D 00003008 904cffff 0 00 00000000 0 0 00 00000000 0 0 00000000 1a 1 0c 0 1 00000022 00000000 ffff 0
D 0000300c fc221234 0 00 00000000 0 0 00 00000000 0 0 00000000 00 0 00 0 0 00000000 00000000 1234 1
D 00003010 00220018 0 00 00000000 0 0 00 00000000 0 0 00000000 00 0 00 0 0 00000000 00000000 0018 1

/* all.f */
src/mips_isa_pkg.sv
src/id_ctrl_pkg.sv
src/gpr_file.sv
src/operand_bypass.sv
src/instr_decoder.sv
src/branch_unit.sv
src/id_ex_reg.sv
src/id_stage.sv
tests/id_stage_props.sv
tests/id_stage_tb.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f all.f --top-module id_stage_tb -o id_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/id_stage_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi
exit 0
